// File: design/fp_types_pkg.sv
package fp_types_pkg;

    localparam int EXP_BIAS = 127;

    // default quiet NaN, every NaN result takes this encoding
    localparam logic [31:0] CANONICAL_NAN = 32'h7fc0_0000;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } float32_fields_t;

    // raw word on ports, field view when decoding
    typedef union packed {
        logic [31:0]     raw;
        float32_fields_t fields;
    } float32_u;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_snan;  // also sets is_nan
    } fp_class_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_e;

    // same bit order as the fflags CSR
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fp_flags_t;

endpackage

// File: design/divide_pkg.sv
package divide_pkg;

    typedef logic [4:0] div_tag_t;

    // biased exponent with room for overflow and underflow
    typedef logic signed [9:0] div_exp_t;

    typedef struct packed {
        fp_types_pkg::float32_u    a;  // dividend
        fp_types_pkg::float32_u    b;  // divisor
        fp_types_pkg::round_mode_e mode;
        div_tag_t                  tag;
    } div_command_t;

    typedef struct packed {
        div_command_t            command;
        fp_types_pkg::fp_class_t class_a;
        fp_types_pkg::fp_class_t class_b;
        logic [23:0]             sig_a;
        logic [23:0]             sig_b;
    } div_classified_t;

    typedef struct packed {
        logic                      sign;
        div_exp_t                  exponent;
        logic [23:0]               sig_a;
        logic [23:0]               sig_b;
        fp_types_pkg::round_mode_e mode;
        div_tag_t                  tag;
        logic                      is_special;  // result already known, no division needed
        logic [31:0]               special_result;
        fp_types_pkg::fp_flags_t   special_flags;
    } div_exponent_t;

    typedef struct packed {
        logic [25:0]               quotient;
        logic                      sticky;
        logic                      sign;
        div_exp_t                  exponent;
        fp_types_pkg::round_mode_e mode;
        div_tag_t                  tag;
        logic                      is_special;
        logic [31:0]               special_result;
        fp_types_pkg::fp_flags_t   special_flags;
    } div_quotient_t;

    typedef struct packed {
        logic [31:0]             result;
        fp_types_pkg::fp_flags_t flags;
        div_tag_t                tag;
    } div_result_t;

endpackage

// File: design/flow_stage.sv
`timescale 1ns/1ps

module flow_stage #(
    parameter type T          = logic [31:0],
    parameter bit  REGISTERED = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_payload,
    output logic out_valid,
    input  logic out_ready,
    output T     out_payload
);

    generate
        if (REGISTERED) begin : g_register
            logic valid_q;
            T     payload_q;

            // a full slot still takes a new item when the old one leaves this cycle
            assign in_ready = !valid_q || out_ready;

            always_ff @(posedge clk) begin
                if (reset) begin
                    valid_q <= 1'b0;
                end else if (in_ready) begin
                    valid_q <= in_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                    payload_q <= in_payload;
                end
            end

            assign out_valid   = valid_q;
            assign out_payload = payload_q;
        end else begin : g_bypass
            assign in_ready    = out_ready;
            assign out_valid   = in_valid;
            assign out_payload = in_payload;
        end
    endgenerate

    // a stalled item keeps its payload until it is taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_payload));

endmodule

// File: design/fp_divide_classify.sv
`timescale 1ns/1ps

module fp_divide_classify (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          command_valid,
    output logic                          command_ready,
    input  divide_pkg::div_command_t      command,
    output logic                          out_valid,
    input  logic                          out_ready,
    output divide_pkg::div_classified_t   out
);
    import fp_types_pkg::*;
    import divide_pkg::*;

    div_classified_t next;

    function automatic fp_class_t classify(float32_u value);
        fp_class_t class_flags;
        logic      exp_zero;
        logic      exp_ones;
        exp_zero = value.fields.exponent == 8'h00;
        exp_ones = value.fields.exponent == 8'hff;
        class_flags.is_zero = exp_zero;  // subnormals count as zero
        class_flags.is_inf  = exp_ones && value.fields.fraction == '0;
        class_flags.is_nan  = exp_ones && value.fields.fraction != '0;
        class_flags.is_snan = class_flags.is_nan && !value.fields.fraction[22];
        return class_flags;
    endfunction

    function automatic logic [23:0] significand(float32_u value);
        if (value.fields.exponent == 8'h00) begin
            return '0;
        end
        return {1'b1, value.fields.fraction};
    endfunction

    always_comb begin
        next.command = command;
        next.class_a = classify(command.a);
        next.class_b = classify(command.b);
        next.sig_a   = significand(command.a);
        next.sig_b   = significand(command.b);
    end

    flow_stage #(
        .T(div_classified_t),
        .REGISTERED(1)
    ) i_flow_stage (
        .clk,
        .reset,
        .in_valid(command_valid),
        .in_ready(command_ready),
        .in_payload(next),
        .out_valid,
        .out_ready,
        .out_payload(out)
    );

endmodule

// File: design/fp_divide_exponent.sv
`timescale 1ns/1ps

module fp_divide_exponent #(
    parameter bit REGISTERED = 1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  divide_pkg::div_classified_t   in,
    output logic                          out_valid,
    input  logic                          out_ready,
    output divide_pkg::div_exponent_t     out
);
    import fp_types_pkg::*;
    import divide_pkg::*;

    div_exponent_t next;
    fp_class_t     class_a;
    fp_class_t     class_b;
    logic          sign;

    always_comb begin
        class_a = in.class_a;
        class_b = in.class_b;
        sign    = in.command.a.fields.sign ^ in.command.b.fields.sign;

        next.sign     = sign;
        next.exponent = $signed({2'b00, in.command.a.fields.exponent})
                      - $signed({2'b00, in.command.b.fields.exponent})
                      + div_exp_t'(EXP_BIAS);
        next.sig_a    = in.sig_a;
        next.sig_b    = in.sig_b;
        next.mode     = in.command.mode;
        next.tag      = in.command.tag;

        next.is_special     = 1'b1;
        next.special_result = '0;
        next.special_flags  = '0;
        if (class_a.is_nan || class_b.is_nan) begin
            next.special_result   = CANONICAL_NAN;
            next.special_flags.nv = class_a.is_snan || class_b.is_snan;
        end else if ((class_a.is_zero && class_b.is_zero) ||
                     (class_a.is_inf && class_b.is_inf)) begin
            next.special_result   = CANONICAL_NAN;  // invalid operation
            next.special_flags.nv = 1'b1;
        end else if (class_a.is_inf) begin
            next.special_result = {sign, 8'hff, 23'h0};
        end else if (class_b.is_zero) begin
            next.special_result   = {sign, 8'hff, 23'h0};
            next.special_flags.dz = 1'b1;
        end else if (class_a.is_zero || class_b.is_inf) begin
            next.special_result = {sign, 31'h0};
        end else begin
            next.is_special = 1'b0;
        end
    end

    flow_stage #(
        .T(div_exponent_t),
        .REGISTERED(REGISTERED)
    ) i_flow_stage (
        .clk,
        .reset,
        .in_valid,
        .in_ready,
        .in_payload(next),
        .out_valid,
        .out_ready,
        .out_payload(out)
    );

endmodule

// File: design/fp_mantissa_divider.sv
`timescale 1ns/1ps

module fp_mantissa_divider (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  divide_pkg::div_exponent_t   in,
    output logic                        out_valid,
    input  logic                        out_ready,
    output divide_pkg::div_quotient_t   out
);
    import divide_pkg::*;

    localparam int QUOTIENT_BITS = 26;

    div_exponent_t item;        // operands and side data of the item in flight
    logic [4:0]    count;       // iterations left
    logic [24:0]   remainder;   // partial remainder which stays below twice the divisor
    logic [25:0]   quotient;
    logic [25:0]   difference;
    logic          busy;
    logic          accept;

    assign busy       = count != 5'd0;
    assign in_ready   = !busy && (!out_valid || out_ready);
    assign accept     = in_valid && in_ready;
    assign difference = {1'b0, remainder} - {2'b00, item.sig_b};

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            out_valid <= 1'b0;
        end else if (accept) begin
            // a special item only waits one cycle
            count     <= in.is_special ? 5'd1 : 5'(QUOTIENT_BITS);
            out_valid <= 1'b0;
        end else if (busy) begin
            count     <= count - 5'd1;
            out_valid <= count == 5'd1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // one restoring step per cycle and the first quotient bit has weight one
    always_ff @(posedge clk) begin
        if (accept) begin
            item      <= in;
            remainder <= {1'b0, in.sig_a};
            quotient  <= '0;
        end else if (busy && !item.is_special) begin
            quotient  <= {quotient[24:0], !difference[25]};
            remainder <= difference[25] ? {remainder[23:0], 1'b0}
                                        : {difference[23:0], 1'b0};
        end
    end

    always_comb begin
        out.quotient       = quotient;
        out.sticky         = remainder != '0;
        out.sign           = item.sign;
        out.exponent       = item.exponent;
        out.mode           = item.mode;
        out.tag            = item.tag;
        out.is_special     = item.is_special;
        out.special_result = item.special_result;
        out.special_flags  = item.special_flags;
    end

    // the quotient is only presented once the counter has run out
    assert property (@(posedge clk) disable iff (reset) busy |-> !out_valid);

    // both significands carry the hidden bit, so the quotient is at least one half
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !item.is_special |-> quotient[25] || quotient[24]);

endmodule

// File: design/fp_divide_round.sv
`timescale 1ns/1ps

module fp_divide_round (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  divide_pkg::div_quotient_t   in,
    output logic                        result_valid,
    input  logic                        result_ready,
    output divide_pkg::div_result_t     result
);
    import fp_types_pkg::*;
    import divide_pkg::*;

    div_result_t next;
    logic [25:0] norm;
    div_exp_t    exp_norm;
    div_exp_t    exp_final;
    logic [23:0] mant;
    logic [24:0] rounded;
    logic        guard;
    logic        sticky;
    logic        inexact;
    logic        round_up;
    logic        to_infinity;  // overflow saturates to infinity rather than the largest finite

    always_comb begin
        // quotient below one needs one more place of shift
        norm     = in.quotient[25] ? in.quotient : {in.quotient[24:0], 1'b0};
        exp_norm = in.quotient[25] ? in.exponent : in.exponent - 10'sd1;
        mant     = norm[25:2];
        guard    = norm[1];
        sticky   = norm[0] || in.sticky;
        inexact  = guard || sticky;

        case (in.mode)
            RNE: begin
                round_up    = guard && (sticky || mant[0]);
                to_infinity = 1'b1;
            end
            RDN: begin
                round_up    = in.sign && inexact;
                to_infinity = in.sign;
            end
            RUP: begin
                round_up    = !in.sign && inexact;
                to_infinity = !in.sign;
            end
            RMM: begin
                round_up    = guard;
                to_infinity = 1'b1;
            end
            default: begin  // RTZ
                round_up    = 1'b0;
                to_infinity = 1'b0;
            end
        endcase

        rounded   = {1'b0, mant} + 25'(round_up);
        exp_final = exp_norm + (rounded[24] ? 10'sd1 : 10'sd0);  // carry out of the mantissa

        next.tag   = in.tag;
        next.flags = '0;
        if (in.is_special) begin
            next.result = in.special_result;
            next.flags  = in.special_flags;
        end else if (exp_final >= 10'sd255) begin
            next.result   = to_infinity ? {in.sign, 8'hff, 23'h0}
                                        : {in.sign, 8'hfe, 23'h7f_ffff};
            next.flags.of = 1'b1;
            next.flags.nx = 1'b1;
        end else if (exp_final <= 10'sd0) begin
            // tiny results go to signed zero
            next.result   = {in.sign, 31'h0};
            next.flags.uf = 1'b1;
            next.flags.nx = 1'b1;
        end else begin
            next.result   = {in.sign, exp_final[7:0], rounded[22:0]};
            next.flags.nx = inexact;
        end
    end

    flow_stage #(
        .T(div_result_t),
        .REGISTERED(1)
    ) i_flow_stage (
        .clk,
        .reset,
        .in_valid,
        .in_ready,
        .in_payload(next),
        .out_valid(result_valid),
        .out_ready(result_ready),
        .out_payload(result)
    );

endmodule

// File: design/fp_divide_unit.sv
`timescale 1ns/1ps

module fp_divide_unit #(
    parameter bit EXPONENT_OUTPUT_REG = 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       command_valid,
    output logic                       command_ready,
    input  divide_pkg::div_command_t   command,
    output logic                       result_valid,
    input  logic                       result_ready,
    output divide_pkg::div_result_t    result
);
    import divide_pkg::*;

    logic            classified_valid;
    logic            classified_ready;
    div_classified_t classified;
    logic            exponent_valid;
    logic            exponent_ready;
    div_exponent_t   exponent;
    logic            quotient_valid;
    logic            quotient_ready;
    div_quotient_t   quotient;

    fp_divide_classify i_fp_divide_classify (
        .clk,
        .reset,
        .command_valid,
        .command_ready,
        .command,
        .out_valid(classified_valid),
        .out_ready(classified_ready),
        .out(classified)
    );

    fp_divide_exponent #(
        .REGISTERED(EXPONENT_OUTPUT_REG)
    ) i_fp_divide_exponent (
        .clk,
        .reset,
        .in_valid(classified_valid),
        .in_ready(classified_ready),
        .in(classified),
        .out_valid(exponent_valid),
        .out_ready(exponent_ready),
        .out(exponent)
    );

    fp_mantissa_divider i_fp_mantissa_divider (
        .clk,
        .reset,
        .in_valid(exponent_valid),
        .in_ready(exponent_ready),
        .in(exponent),
        .out_valid(quotient_valid),
        .out_ready(quotient_ready),
        .out(quotient)
    );

    fp_divide_round i_fp_divide_round (
        .clk,
        .reset,
        .in_valid(quotient_valid),
        .in_ready(quotient_ready),
        .in(quotient),
        .result_valid,
        .result_ready,
        .result
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;  // released just after an edge, like the other inputs
    end

endmodule

// File: verif/tb_fp_divide_unit.sv
`timescale 1ns/1ps

module tb_fp_divide_unit;
    import fp_types_pkg::*;
    import divide_pkg::*;

    localparam int NUM_TESTS   = 21;
    localparam int CYCLE_LIMIT = NUM_TESTS * 29 * 2 + 100;

    localparam fp_flags_t NO_FLAGS = 5'b00000;
    localparam fp_flags_t NV       = 5'b10000;
    localparam fp_flags_t DZ       = 5'b01000;
    localparam fp_flags_t NX       = 5'b00001;
    localparam fp_flags_t OF_NX    = 5'b00101;
    localparam fp_flags_t UF_NX    = 5'b00011;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        round_mode_e mode;
        logic [31:0] expected;
        fp_flags_t   flags;
    } vector_t;

    logic         clk;
    logic         reset;
    logic         command_valid;
    logic         command_ready;
    div_command_t command;
    logic         result_valid;
    logic         result_ready;
    div_result_t  result;

    vector_t vectors[NUM_TESTS];
    string   names[NUM_TESTS];
    bit      returned[NUM_TESTS];
    int      next_tag;  // results must come back in issue order
    int      received;
    int      passed;
    int      failed;
    int      errors;
    int      cycles;
    integer  seed;

    tb_clock_gen #(
        .HALF_PERIOD(4),
        .RESET_CYCLES(16)
    ) i_tb_clock_gen (
        .clk,
        .reset
    );

    fp_divide_unit #(
        .EXPONENT_OUTPUT_REG(1)
    ) i_fp_divide_unit (
        .clk,
        .reset,
        .command_valid,
        .command_ready,
        .command,
        .result_valid,
        .result_ready,
        .result
    );

    task automatic set_vector(input int index, input string name, input logic [31:0] a,
                              input logic [31:0] b, input round_mode_e mode,
                              input logic [31:0] expected, input fp_flags_t flags);
        names[index]            = name;
        vectors[index].a        = a;
        vectors[index].b        = b;
        vectors[index].mode     = mode;
        vectors[index].expected = expected;
        vectors[index].flags    = flags;
    endtask

    task automatic fill_table();
        set_vector(0, "6/3", 32'h40c0_0000, 32'h4040_0000, RNE, 32'h4000_0000, NO_FLAGS);
        set_vector(1, "-1/0.5", 32'hbf80_0000, 32'h3f00_0000, RNE, 32'hc000_0000, NO_FLAGS);
        set_vector(2, "7/2", 32'h40e0_0000, 32'h4000_0000, RTZ, 32'h4060_0000, NO_FLAGS);
        // 1/3 has guard and sticky both set
        set_vector(3, "1/3 rne", 32'h3f80_0000, 32'h4040_0000, RNE, 32'h3eaa_aaab, NX);
        set_vector(4, "1/3 rtz", 32'h3f80_0000, 32'h4040_0000, RTZ, 32'h3eaa_aaaa, NX);
        set_vector(5, "1/3 rdn", 32'h3f80_0000, 32'h4040_0000, RDN, 32'h3eaa_aaaa, NX);
        set_vector(6, "1/3 rup", 32'h3f80_0000, 32'h4040_0000, RUP, 32'h3eaa_aaab, NX);
        set_vector(7, "1/3 rmm", 32'h3f80_0000, 32'h4040_0000, RMM, 32'h3eaa_aaab, NX);
        set_vector(8, "-1/3 rdn", 32'hbf80_0000, 32'h4040_0000, RDN, 32'hbeaa_aaab, NX);
        set_vector(9, "0/0", 32'h0000_0000, 32'h0000_0000, RNE, 32'h7fc0_0000, NV);
        set_vector(10, "inf/inf", 32'h7f80_0000, 32'h7f80_0000, RNE, 32'h7fc0_0000, NV);
        set_vector(11, "1/0", 32'h3f80_0000, 32'h0000_0000, RNE, 32'h7f80_0000, DZ);
        set_vector(12, "-1/inf", 32'hbf80_0000, 32'h7f80_0000, RNE, 32'h8000_0000, NO_FLAGS);
        set_vector(13, "snan/1", 32'h7f80_0001, 32'h3f80_0000, RNE, 32'h7fc0_0000, NV);
        set_vector(14, "1/qnan", 32'h3f80_0000, 32'h7fc0_0000, RNE, 32'h7fc0_0000, NO_FLAGS);
        set_vector(15, "subnormal/1", 32'h0000_0001, 32'h3f80_0000, RNE, 32'h0000_0000,
                   NO_FLAGS);
        // twice the largest finite value overflows in every mode
        set_vector(16, "max/0.5 rne", 32'h7f7f_ffff, 32'h3f00_0000, RNE, 32'h7f80_0000, OF_NX);
        set_vector(17, "max/0.5 rtz", 32'h7f7f_ffff, 32'h3f00_0000, RTZ, 32'h7f7f_ffff, OF_NX);
        set_vector(18, "-max/0.5 rup", 32'hff7f_ffff, 32'h3f00_0000, RUP, 32'hff7f_ffff, OF_NX);
        set_vector(19, "min/4 rne", 32'h0080_0000, 32'h4080_0000, RNE, 32'h0000_0000, UF_NX);
        set_vector(20, "-min/4 rup", 32'h8080_0000, 32'h4080_0000, RUP, 32'h8000_0000, UF_NX);
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the edge that took the command
    task automatic send_command(input int index);
        command_valid = 1'b1;
        command.a.raw = vectors[index].a;
        command.b.raw = vectors[index].b;
        command.mode  = vectors[index].mode;
        command.tag   = div_tag_t'(index);
        @(negedge clk);
        while (!command_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_result(input div_result_t actual);
        int index;
        bit ok;
        index = actual.tag;
        ok    = 1'b1;
        received++;
        assert (index < NUM_TESTS) else begin
            $display("a result came back with tag %0d, which was never issued", index);
            errors++;
            return;
        end
        assert (next_tag < NUM_TESTS && index == next_tag) else begin
            $display("ERROR %s: tag expected %0d actual %0d", names[index], next_tag, index);
            ok = 1'b0;
        end
        assert (!returned[index]) else begin
            $display("tag %0d came back a second time", index);
            ok = 1'b0;
        end
        assert (actual.result == vectors[index].expected) else begin
            $display("ERROR %s: result expected %h actual %h", names[index],
                     vectors[index].expected, actual.result);
            ok = 1'b0;
        end
        assert (actual.flags == vectors[index].flags) else begin
            $display("ERROR %s: flags expected %b actual %b", names[index],
                     vectors[index].flags, actual.flags);
            ok = 1'b0;
        end
        returned[index] = 1'b1;
        next_tag++;
        if (ok) begin
            passed++;
        end else begin
            failed++;
            errors++;
        end
        $display("%s %s", names[index], ok ? "ok" : "mismatch");
    endtask

    // values are stable at the falling edge and transfer on the next rising edge
    always @(negedge clk) begin
        if (!reset && result_valid && result_ready) begin
            check_result(result);
        end
    end

    initial begin
        seed         = 72905;
        result_ready = 1'b0;
        @(negedge reset);
        forever begin
            @(posedge clk);
            #1;
            result_ready = ($random(seed) & 3) != 0;  // ready about three cycles in four
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d results back",
                 cycles, received, NUM_TESTS);
        $display("Test failed");
        $finish;
    end

    initial begin
        command_valid = 1'b0;
        command       = '0;
        next_tag      = 0;
        received      = 0;
        passed        = 0;
        failed        = 0;
        errors        = 0;
        foreach (returned[i]) begin
            returned[i] = 1'b0;
        end
        fill_table();
        @(negedge reset);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            send_command(i);
        end
        command_valid = 1'b0;
        wait (received >= NUM_TESTS);
        repeat (40) @(posedge clk);  // a stray result would show up as a repeated tag
        foreach (returned[i]) begin
            assert (returned[i]) else begin
                $display("no result came back for %s", names[i]);
                errors++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, passed, failed, errors);
        if (errors == 0 && passed == NUM_TESTS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
design/fp_types_pkg.sv
design/divide_pkg.sv
design/flow_stage.sv
design/fp_divide_classify.sv
design/fp_divide_exponent.sv
design/fp_mantissa_divider.sv
design/fp_divide_round.sv
design/fp_divide_unit.sv
verif/tb_clock_gen.sv
verif/tb_fp_divide_unit.sv

// File: Bender.yml
package:
  name: fp_divide_unit

sources:
  - files:
      - design/fp_types_pkg.sv
      - design/divide_pkg.sv
      - design/flow_stage.sv
      - design/fp_divide_classify.sv
      - design/fp_divide_exponent.sv
      - design/fp_mantissa_divider.sv
      - design/fp_divide_round.sv
      - design/fp_divide_unit.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_fp_divide_unit.sv
